//--- Bender.yml
package:
  name: exLane

sources:
  - include_dirs:
      - src
    files:
      - src/exLanePkg.sv
      - src/exLaneShifter.sv
      - src/exLaneDecode.sv
      - src/exLaneExecute.sv
      - src/exLaneResult.sv
      - src/exLaneTop.sv
  - target: simulation
    include_dirs:
      - src
    files:
      - sim/exLaneTb_sva.sv
      - sim/exLaneTb.sv

//--- sim/exLaneTb.sv
/*
 Testbench for the lane execute stage. Ops and their expected results
 come from sim/exLane_testdata.txt, 14 hex words per op. Stall is
 random with a fixed seed. The last op in the file must fault, after
 which the lane has to stay frozen. The run stops at the first mismatch.
*/

`timescale 1ns/1ps

`include "exLane_config.svh"

module exLaneTb
	import exLanePkg::*;
();

	localparam int COLS    = 14;  // Hex words per op
	localparam int MAX_OPS = 64;

	typedef struct packed {
		laneWb_t                    wb;
		logic [`EXLANE_REGID_W-1:0] heldId;
		logic                       fault;
	} expEntry_t;

	logic                       clock;
	logic                       rstN;
	laneIn_t                    opIn;
	logic                       opValid;
	logic                       srT;
	logic                       flush;
	logic                       stall;
	laneWb_t                    wb;
	logic [`EXLANE_REGID_W-1:0] heldId;
	logic                       exHold;

	logic [63:0] testMem [0:COLS*MAX_OPS-1];
	expEntry_t   expQ[$];  // Accepted ops not yet out
	int          seed = 32'h129d_a431;
	int          numOps;
	int          cycleCount;
	int          cycleLimit;

	exLaneTop exLaneTop_inst (.clock(clock), .rstN(rstN), .opIn(opIn), .opValid(opValid),
		.srT(srT), .flush(flush), .stall(stall), .wb(wb), .heldId(heldId), .exHold(exHold));

	initial clock = 1'b0;
	always #50 clock = !clock;

	task automatic checkWb(input laneWb_t got, input laneWb_t exp);
		if (got.valid !== exp.valid || (exp.valid &&
				(got.regId !== exp.regId || got.value !== exp.value))) begin
			$display("[ERROR] %0d ns: wb valid %0b id %h value %h, expected %0b %h %h",
				$time, got.valid, got.regId, got.value, exp.valid, exp.regId, exp.value);
			$display("Testbench failed");
			$fatal(1, "Writeback mismatch");
		end
	endtask

	task automatic checkHeld(input logic [`EXLANE_REGID_W-1:0] gotId, input logic gotHold,
		input logic [`EXLANE_REGID_W-1:0] expId, input logic expHold);
		if (gotId !== expId || gotHold !== expHold) begin
			$display("[ERROR] %0d ns: heldId %h exHold %b, expected %h %b",
				$time, gotId, gotHold, expId, expHold);
			$display("Testbench failed");
			$fatal(1, "Held destination or fault mismatch");
		end
	endtask

	task automatic driveOp(input int idx);
		int b;
		b            = idx * COLS;
		opIn         = '0;  // rsId and rtId unused by this stage
		opIn.cmd.cc  = laneCc_e'(testMem[b][1:0]);
		opIn.cmd.op  = laneOp_e'(testMem[b+1][5:0]);
		opIn.ixt     = testMem[b+2][7:0];
		opIn.rmId    = testMem[b+3][`EXLANE_REGID_W-1:0];
		opIn.rsVal   = testMem[b+4];
		opIn.rtVal   = testMem[b+5];
		opIn.rmVal   = testMem[b+6];
		opIn.imm     = testMem[b+7][`EXLANE_IMM_W-1:0];
		srT          = testMem[b+8][0];
		flush        = testMem[b+9][0];
		opValid      = 1'b1;
	endtask

	function automatic expEntry_t readExpect(input int idx);
		expEntry_t e;
		int        b;
		b          = idx * COLS;
		e.wb.valid = 1'b1;  // Every accepted op leaves a valid writeback
		e.wb.regId = testMem[b+10][`EXLANE_REGID_W-1:0];
		e.wb.value = testMem[b+11];
		e.heldId   = testMem[b+12][`EXLANE_REGID_W-1:0];
		e.fault    = testMem[b+13][0];
		return e;
	endfunction

	always @(posedge clock) begin
		cycleCount++;
		if (cycleLimit > 0 && cycleCount > cycleLimit) begin
			$display("Timeout: the run did not finish within %0d cycles", cycleLimit);
			$display("Testbench failed");
			$fatal(1, "Timeout");
		end
	end

	initial begin
		expEntry_t                  nextExp;
		laneWb_t                    frozenWb;
		logic [`EXLANE_REGID_W-1:0] frozenId;
		logic                       stallQ;
		logic                       holdQ;
		logic                       pending;
		int                         lineIdx;
		int                         memIdx;
		opIn       = '0;
		opValid    = 1'b0;
		srT        = 1'b0;
		flush      = 1'b0;
		stall      = 1'b0;
		rstN       = 1'b1;
		cycleCount = 0;
		cycleLimit = 0;
		numOps     = 0;
		for (memIdx = 0; memIdx < COLS * MAX_OPS; memIdx++)
			testMem[memIdx] = {32'hFFFF_FFFF, memIdx};  // Above every cc code
		$readmemh("sim/exLane_testdata.txt", testMem);
		while (numOps < MAX_OPS && testMem[numOps*COLS] < 64'd4)
			numOps++;
		if (numOps == 0) begin
			$display("No ops could be read from sim/exLane_testdata.txt");
			$display("Testbench failed");
			$fatal(1, "Missing test data");
		end
		cycleLimit = 4 * numOps + 20;

		#10 rstN = 1'b0;
		repeat (2) @(posedge clock);
		@(negedge clock);
		rstN = 1'b1;
		checkWb(wb, '0);
		checkHeld(heldId, exHold, `EXLANE_ZZR, 1'b0);

		stallQ  = 1'b1;  // Last edge was still in reset
		holdQ   = 1'b0;
		pending = 1'b0;
		lineIdx = 0;
		while (lineIdx < numOps || pending || expQ.size() > 0) begin
			if (!stallQ && !holdQ) begin  // Previous edge moved the pipe
				if (pending) begin
					expQ.push_back(readExpect(lineIdx));
					lineIdx++;
					pending = 1'b0;
				end
				if (wb.valid) begin
					if (expQ.size() == 0) begin
						$display("A writeback came out with no op waiting for it");
						$display("Testbench failed");
						$fatal(1, "Unexpected writeback");
					end
					nextExp = expQ.pop_front();
					checkWb(wb, nextExp.wb);
					checkHeld(heldId, exHold, nextExp.heldId, nextExp.fault);
				end
			end
			holdQ  = exHold;
			stallQ = ($random(seed) & 3) == 0;  // About one cycle in four
			stall  = stallQ;
			if (!pending) begin
				if (lineIdx < numOps) begin
					driveOp(lineIdx);
					pending = 1'b1;
				end else
					opValid = 1'b0;
			end
			@(negedge clock);
		end

		// An op offered behind the fault must never come out
		frozenWb = wb;
		frozenId = heldId;
		stall    = 1'b0;
		driveOp(0);
		repeat (4) begin
			@(negedge clock);
			checkWb(wb, frozenWb);
			checkHeld(heldId, exHold, frozenId, 1'b1);
		end

		$display("Testbench passed");
		$finish;
	end

endmodule

//--- sim/exLaneTb_sva.sv
/*
 Assertions bound into exLaneTop. They cover the output reset state,
 output stability across an edge frozen by stall or the fault hold,
 and the stickiness of exHold. wb.value has no reset, so it is only
 compared once wb.valid is set.
*/

`timescale 1ns/1ps

`include "exLane_config.svh"

module exLaneTbSva
	import exLanePkg::*;
(
	input logic                       clock,
	input logic                       rstN,
	input logic                       stall,
	input laneWb_t                    wb,
	input logic [`EXLANE_REGID_W-1:0] heldId,
	input logic                       exHold
);

	resetState: assert property (@(posedge clock)
		!rstN |-> (!wb.valid && !exHold && heldId == `EXLANE_ZZR))
		else $error("Outputs are not in their reset state during reset");

	frozenOutputs: assert property (@(posedge clock) disable iff (!rstN)
		(stall || exHold) |=> ($stable({wb.valid, wb.regId, heldId, exHold}) &&
		(!wb.valid || $stable(wb.value))))
		else $error("Outputs changed across a frozen clock edge");

	holdSticky: assert property (@(posedge clock) disable iff (!rstN)
		exHold |=> exHold)
		else $error("exHold dropped before reset");

endmodule

bind exLaneTop exLaneTbSva exLaneTbSva_inst (.*);

//--- sim/exLane_testdata.txt
// cc op ixt rmId rsVal rtVal rmVal imm srT flush expRegId expValue expHeldId expFault
// All hex, one op per line. The last op must be the faulting one.
0 04 00 05 0 0 0 1FFFFFF80 0 0 05 FFFFFFFFFFFFFF80 3F 0
0 04 01 06 0011223344556677 0 0 AB 0 0 06 11223344556677AB 3F 0
0 04 02 07 1234 0 0 BEEF 0 0 07 1234BEEF 3F 0
0 04 03 08 CAFEF00D 0 0 DEADBEEF 0 0 08 CAFEF00DDEADBEEF 3F 0
0 03 00 09 80 0 0 0 0 0 09 FFFFFFFFFFFFFF80 3F 0
0 03 05 0A FFFFFFFFFFFF8001 0 0 0 0 0 0A 8001 3F 0
0 02 00 0B 0 0 DEADBEEFCAFEBABE 0 0 0 3F DEADBEEFCAFEBABE 3F 0
0 0C 01 0C 0 0 0 0 1 0 0C 1 3F 0
0 0C 02 0D 0 0 0 0 1 0 0D 0 3F 0
1 04 00 0E 0 0 0 5 0 0 3F 0 3F 0
2 04 00 0E 0 0 0 6 0 0 3F 0 3F 0
0 04 00 0E 0 0 0 9 1 1 3F 0 3F 0
2 04 00 0F 0 0 0 7 1 0 0F 7 3F 0
3 03 04 10 1FF 0 0 0 0 0 10 FF 3F 0
0 05 00 11 80000000 FC 0 0 0 0 11 FFFFFFFFF8000000 3F 0
0 06 00 12 FFFFFFFF 20 0 0 0 0 12 0 3F 0
0 05 00 13 80000000 E0 0 0 0 0 13 FFFFFFFFFFFFFFFF 3F 0
0 07 00 14 8000000000000000 F8 0 0 0 0 14 FF80000000000000 3F 0
0 08 00 15 1 3F 0 0 0 0 15 8000000000000000 3F 0
0 08 00 16 FFFFFFFFFFFFFFFF C0 0 0 0 0 16 0 3F 0
0 09 00 17 0 0 0 0 0 0 3F 0 17 0
0 0A 00 18 0 0 0 0 0 0 3F 0 18 0
0 0B 00 19 0 0 0 0 0 0 3F 0 19 0
0 01 00 1A 0 0 0 0 0 0 3F 0 3F 1

//--- src.f
+incdir+src
src/exLanePkg.sv
src/exLaneShifter.sv
src/exLaneDecode.sv
src/exLaneExecute.sv
src/exLaneResult.sv
src/exLaneTop.sv
sim/exLaneTb_sva.sv
sim/exLaneTb.sv

//--- src/exLaneDecode.sv
/*
 Decode register of the lane. Gates the op with its condition code
 and the branch flush, then captures the op, operands and T bit.
 A gated op still leaves as a valid NOP. Nothing is captured while
 stall or the fault hold is high, so upstream must keep opIn steady.
*/

`timescale 1ns/1ps

`include "exLane_config.svh"

module exLaneDecode
	import exLanePkg::*;
(
	input  logic     clock,
	input  logic     rstN,
	input  logic     stall,
	input  logic     hold,
	input  laneIn_t  opIn,
	input  logic     opValid,
	input  logic     srT,
	input  logic     flush,
	output laneDec_t dec
);

	logic                       enable;
	logic                       freeze;
	logic                       validQ;
	laneOp_e                    opQ;
	laneIxt_u                   ixtQ;
	logic [`EXLANE_REGID_W-1:0] rmIdQ;
	logic [`EXLANE_DATA_W-1:0]  rsValQ;
	logic [`EXLANE_DATA_W-1:0]  rtValQ;
	logic [`EXLANE_DATA_W-1:0]  rmValQ;
	logic [`EXLANE_IMM_W-1:0]   immQ;
	logic                       srTQ;

	assign freeze = stall | hold;

	always_comb begin
		case (opIn.cmd.cc)
			CC_AL:   enable = 1'b1;
			CC_NV:   enable = 1'b0;
			CC_CT:   enable = srT;   // Execute if T set
			default: enable = !srT;  // CF
		endcase
		if (flush)
			enable = 1'b0;
	end

	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			validQ <= 1'b0;
			opQ    <= OP_NOP;
		end else if (!freeze) begin
			validQ <= opValid;
			opQ    <= (opValid && enable) ? opIn.cmd.op : OP_NOP;
		end
	end

	always_ff @(posedge clock) begin
		if (!freeze) begin
			ixtQ   <= opIn.ixt;
			rmIdQ  <= opIn.rmId;
			rsValQ <= opIn.rsVal;
			rtValQ <= opIn.rtVal;
			rmValQ <= opIn.rmVal;
			immQ   <= opIn.imm;
			srTQ   <= srT;
		end
	end

	assign dec = '{valid: validQ, op: opQ, ixt: ixtQ, rmId: rmIdQ, rsVal: rsValQ,
		rtVal: rtValQ, rmVal: rmValQ, imm: immQ, srT: srTQ};

endmodule

//--- src/exLaneExecute.sv
/*
 Combinational execute for ops that finish in the first stage.
 ALU3, MUL3 and FPU3 only report their destination as held.
 INVOP, an unknown opcode or sub-op, a bad MOVIR selector and BREAK
 raise exFault. Results are valid only with dec.valid.
*/

`timescale 1ns/1ps

`include "exLane_config.svh"

module exLaneExecute
	import exLanePkg::*;
(
	input  laneDec_t                   dec,
	output laneWb_t                    exWb,
	output logic [`EXLANE_REGID_W-1:0] exHeldId,
	output logic                       exFault
);

	logic        arith;
	logic        opFault;
	logic [31:0] sh32;
	logic [63:0] sh64;
	logic [63:0] rs;

	assign rs    = dec.rsVal;
	assign arith = (dec.op == OP_SHAD3) || (dec.op == OP_SHADQ3);

	exLaneShifter shifter_inst (
		.rsVal  (dec.rsVal),
		.amount (dec.rtVal[7:0]),
		.arith  (arith),
		.sh32   (sh32),
		.sh64   (sh64)
	);

	always_comb begin
		exWb.valid = dec.valid;
		exWb.regId = `EXLANE_ZZR;
		exWb.value = '0;
		exHeldId   = `EXLANE_ZZR;
		opFault    = 1'b0;
		case (dec.op)
			OP_NOP: ;
			OP_MOVRM: exWb.value = dec.rmVal;  // Store data, no register write
			OP_CONVRR: begin
				exWb.regId = dec.rmId;
				case (dec.ixt.movIr.sel)
					EXT_SB:  exWb.value = {{56{rs[7]}}, rs[7:0]};
					EXT_SW:  exWb.value = {{48{rs[15]}}, rs[15:0]};
					EXT_SL:  exWb.value = {{32{rs[31]}}, rs[31:0]};
					EXT_UB:  exWb.value = {56'b0, rs[7:0]};
					EXT_UW:  exWb.value = {48'b0, rs[15:0]};
					EXT_UL:  exWb.value = {32'b0, rs[31:0]};
					default: exWb.value = rs;
				endcase
			end
			OP_MOVIR: begin
				exWb.regId = dec.rmId;
				case (dec.ixt.movIr.sel)
					LD_LDI:  exWb.value = {{31{dec.imm[32]}}, dec.imm};
					LD_SH8:  exWb.value = {rs[55:0], dec.imm[7:0]};
					LD_SH16: exWb.value = {rs[47:0], dec.imm[15:0]};
					LD_SH32: exWb.value = {rs[31:0], dec.imm[31:0]};
					default: begin
						exWb.regId = `EXLANE_ZZR;
						opFault    = 1'b1;
					end
				endcase
			end
			OP_SHAD3:  {exWb.regId, exWb.value} = {dec.rmId, {32{sh32[31]}}, sh32};
			OP_SHLD3:  {exWb.regId, exWb.value} = {dec.rmId, 32'b0, sh32};
			OP_SHADQ3, OP_SHLDQ3: {exWb.regId, exWb.value} = {dec.rmId, sh64};
			OP_ALU3, OP_MUL3, OP_FPU3: exHeldId = dec.rmId;  // Produced later
			OP_OPIXS: begin
				case (dec.ixt.sub.subOp)
					IXS_NOP:   ;
					IXS_MOVT:  {exWb.regId, exWb.value} = {dec.rmId, 63'b0, dec.srT};
					IXS_MOVNT: {exWb.regId, exWb.value} = {dec.rmId, 63'b0, !dec.srT};
					default:   opFault = 1'b1;
				endcase
			end
			OP_OPIXT: begin
				case (dec.ixt.sub.subOp)
					IXT_NOP, IXT_SLEEP: ;
					default: opFault = 1'b1;  // BREAK or unknown
				endcase
			end
			default: opFault = 1'b1;  // INVOP and unassigned opcodes
		endcase
	end

	assign exFault = opFault & dec.valid;

endmodule

//--- src/exLanePkg.sv
/*
 Types for the secondary-lane first execute stage.
 The command word is a 2-bit condition code over a 6-bit opcode.
 The extension word is read as a load/extension selector for MOVIR
 and CONVRR, or as a 6-bit sub-op for OPIXS/OPIXT.
*/

`include "exLane_config.svh"

package exLanePkg;

	typedef enum logic [5:0] {
		OP_NOP    = 6'h00,
		OP_INVOP  = 6'h01,
		OP_MOVRM  = 6'h02,
		OP_CONVRR = 6'h03,
		OP_MOVIR  = 6'h04,
		OP_SHAD3  = 6'h05,
		OP_SHLD3  = 6'h06,
		OP_SHADQ3 = 6'h07,
		OP_SHLDQ3 = 6'h08,
		OP_ALU3   = 6'h09,
		OP_MUL3   = 6'h0A,
		OP_FPU3   = 6'h0B,
		OP_OPIXS  = 6'h0C,
		OP_OPIXT  = 6'h0D
	} laneOp_e;

	typedef enum logic [1:0] {CC_AL, CC_NV, CC_CT, CC_CF} laneCc_e;

	typedef enum logic [3:0] {LD_LDI, LD_SH8, LD_SH16, LD_SH32} laneLd_e;

	// CONVRR reuses the load selector field
	typedef enum logic [3:0] {
		EXT_SB = 4'h0,
		EXT_SW = 4'h1,
		EXT_SL = 4'h2,
		EXT_UB = 4'h4,
		EXT_UW = 4'h5,
		EXT_UL = 4'h6
	} laneExt_e;

	typedef enum logic [5:0] {IXS_NOP, IXS_MOVT, IXS_MOVNT} laneIxsOp_e;
	typedef enum logic [5:0] {IXT_NOP, IXT_SLEEP, IXT_BREAK} laneIxtOp_e;

	typedef struct packed {
		laneCc_e cc;
		laneOp_e op;
	} laneCmd_t;

	typedef union packed {
		struct packed {
			logic [3:0] resv;
			logic [3:0] sel;    // laneLd_e or laneExt_e
		} movIr;
		struct packed {
			logic [1:0] resv;
			logic [5:0] subOp;  // laneIxsOp_e or laneIxtOp_e
		} sub;
	} laneIxt_u;

	typedef struct packed {
		laneCmd_t                   cmd;
		laneIxt_u                   ixt;
		logic [`EXLANE_REGID_W-1:0] rsId;
		logic [`EXLANE_REGID_W-1:0] rtId;
		logic [`EXLANE_REGID_W-1:0] rmId;
		logic [`EXLANE_DATA_W-1:0]  rsVal;
		logic [`EXLANE_DATA_W-1:0]  rtVal;
		logic [`EXLANE_DATA_W-1:0]  rmVal;
		logic [`EXLANE_IMM_W-1:0]   imm;
	} laneIn_t;

	typedef struct packed {
		logic                       valid;
		laneOp_e                    op;     // NOP when gated
		laneIxt_u                   ixt;
		logic [`EXLANE_REGID_W-1:0] rmId;
		logic [`EXLANE_DATA_W-1:0]  rsVal;
		logic [`EXLANE_DATA_W-1:0]  rtVal;
		logic [`EXLANE_DATA_W-1:0]  rmVal;
		logic [`EXLANE_IMM_W-1:0]   imm;
		logic                       srT;    // T bit seen at decode
	} laneDec_t;

	typedef struct packed {
		logic                       valid;
		logic [`EXLANE_REGID_W-1:0] regId;
		logic [`EXLANE_DATA_W-1:0]  value;
	} laneWb_t;

endpackage

//--- src/exLaneResult.sv
/*
 Output register of the stage. Holds writeback and held ID while
 stall or the fault hold is high. exHold is sticky until reset and
 freezes the whole lane, so ops behind a fault never come out.
*/

`timescale 1ns/1ps

`include "exLane_config.svh"

module exLaneResult
	import exLanePkg::*;
(
	input  logic                       clock,
	input  logic                       rstN,
	input  logic                       stall,
	input  laneWb_t                    exWb,
	input  logic [`EXLANE_REGID_W-1:0] exHeldId,
	input  logic                       exFault,
	output laneWb_t                    wb,
	output logic [`EXLANE_REGID_W-1:0] heldId,
	output logic                       exHold
);

	logic                       freeze;
	logic                       wbValidQ;
	logic [`EXLANE_REGID_W-1:0] wbIdQ;
	logic [`EXLANE_DATA_W-1:0]  wbValQ;

	assign freeze = stall | exHold;

	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			wbValidQ <= 1'b0;
			wbIdQ    <= `EXLANE_ZZR;
			heldId   <= `EXLANE_ZZR;
			exHold   <= 1'b0;
		end else if (!freeze) begin
			wbValidQ <= exWb.valid;
			wbIdQ    <= exWb.regId;
			heldId   <= exHeldId;
			exHold   <= exFault;  // Stays set, freeze blocks any clear
		end
	end

	always_ff @(posedge clock) begin
		if (!freeze)
			wbValQ <= exWb.value;
	end

	assign wb = '{valid: wbValidQ, regId: wbIdQ, value: wbValQ};

endmodule

//--- src/exLaneShifter.sv
/*
 Barrel shifter for SHAD/SHLD in 32 and 64 bits.
 The 8-bit amount is two's complement. Positive shifts left,
 negative shifts right by the magnitude. A magnitude at or above
 the width gives zero, or all sign bits for an arithmetic shift.
*/

`timescale 1ns/1ps

module exLaneShifter (
	input  logic [63:0] rsVal,
	input  logic [7:0]  amount,
	input  logic        arith,
	output logic [31:0] sh32,
	output logic [63:0] sh64
);

	logic       left;
	logic [8:0] mag;     // -128 needs 9 bits
	logic       fill32;
	logic       fill64;
	logic [63:0] res32;  // Low word holds the 32-bit result

	function automatic logic [63:0] shiftVal(input logic [63:0] val, input logic [8:0] sh,
		input logic toLeft, input logic fill);
		logic [127:0] wide;
		logic [63:0]  res;
		wide = {{64{fill}}, val} >> sh;
		if (toLeft)
			res = (sh >= 9'd64) ? '0 : (val << sh);
		else
			res = (sh >= 9'd64) ? {64{fill}} : wide[63:0];
		return res;
	endfunction

	assign left   = !amount[7];
	assign mag    = left ? {1'b0, amount} : (9'd256 - {1'b0, amount});
	assign fill32 = arith & rsVal[31];
	assign fill64 = arith & rsVal[63];

	// 32-bit form runs on the low word widened with its own fill bits
	assign res32 = shiftVal({{32{fill32}}, rsVal[31:0]}, mag, left, fill32);
	assign sh32  = res32[31:0];
	assign sh64  = shiftVal(rsVal, mag, left, fill64);

endmodule

//--- src/exLaneTop.sv
/*
 First execute stage of a secondary lane: decode register,
 combinational execute, result register. Two ops can be in flight.
 stall comes from the other lanes and freezes both registers.
*/

`timescale 1ns/1ps

`include "exLane_config.svh"

module exLaneTop
	import exLanePkg::*;
(
	input  logic                       clock,
	input  logic                       rstN,
	input  laneIn_t                    opIn,
	input  logic                       opValid,
	input  logic                       srT,
	input  logic                       flush,
	input  logic                       stall,
	output laneWb_t                    wb,
	output logic [`EXLANE_REGID_W-1:0] heldId,
	output logic                       exHold
);

	laneDec_t                   dec;
	laneWb_t                    exWb;
	logic [`EXLANE_REGID_W-1:0] exHeldId;
	logic                       exFault;

	exLaneDecode decode_inst (.clock(clock), .rstN(rstN), .stall(stall), .hold(exHold),
		.opIn(opIn), .opValid(opValid), .srT(srT), .flush(flush), .dec(dec));

	exLaneExecute execute_inst (.dec(dec), .exWb(exWb), .exHeldId(exHeldId),
		.exFault(exFault));

	exLaneResult result_inst (.clock(clock), .rstN(rstN), .stall(stall), .exWb(exWb),
		.exHeldId(exHeldId), .exFault(exFault), .wb(wb), .heldId(heldId), .exHold(exHold));

endmodule

//--- src/exLane_config.svh
/*
 Sizes shared by every stage of the secondary-lane execute block.
 The data width and the register-ID width are fixed by the packed
 structs in the package. Changing them alone does not give a working
 narrower lane. ZZR is the zero register, which means "no write"
 on writeback and "nothing held" on the held-destination output.
*/

`ifndef EXLANE_CONFIG_SVH
`define EXLANE_CONFIG_SVH

// Register value width
`define EXLANE_DATA_W 64

// Register ID width
`define EXLANE_REGID_W 6

// Zero register ID, used as the no-write destination
`define EXLANE_ZZR 6'h3F

// Immediate width from the decoder, top bit is the sign extension
`define EXLANE_IMM_W 33

`endif
